// File: hdl/phys_regfile.sv
`timescale 1ns/1ns
`default_nettype none

module phys_regfile (
    input  logic                            clk,
    input  logic                            rst_n,
    input  regread_pkg::preg_t              raddr [regread_pkg::int_read_ports],
    input  logic [regread_pkg::wb_size-1:0] we,
    input  regread_pkg::preg_t              waddr [regread_pkg::wb_size],
    input  regread_pkg::word_t              wdata [regread_pkg::wb_size],
    output regread_pkg::word_t              rdata [regread_pkg::int_read_ports]
);
    import regread_pkg::*;

    word_t regs [preg_size];

    // Register 0 is skipped on write, so it keeps the zero it got at reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int r = 0; r < preg_size; r++) begin
                regs[r] <= '0;
            end
        end else begin
            for (int w = 0; w < wb_size; w++) begin
                if (we[w] && waddr[w] != '0) begin
                    regs[waddr[w]] <= wdata[w];
                end
            end
        end
    end

    always_comb begin
        for (int p = 0; p < int_read_ports; p++) begin
            rdata[p] = regs[raddr[p]];
        end
    end

    // Rename never hands one physical register to two results in flight,
    // so two writers on one register means the allocator is broken
    for (genvar a = 0; a < wb_size; a++) begin : g_wr_a
        for (genvar b = a + 1; b < wb_size; b++) begin : g_wr_b
            write_unique: assert property (
                @(posedge clk) disable iff (!rst_n)
                !(we[a] && we[b] && waddr[a] == waddr[b] && waddr[a] != '0)
            ) else $error("phys_regfile: write ports %0d and %0d both target p%0d",
                          a, b, waddr[a]);
        end
    end

endmodule

`default_nettype wire

// File: hdl/read_port_share.sv
`timescale 1ns/1ns
`default_nettype none

module read_port_share (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               primary_en,
    input  regread_pkg::preg_t primary_rs1,
    input  regread_pkg::preg_t primary_rs2,
    input  logic               secondary_en,
    input  regread_pkg::preg_t secondary_rs1,
    input  regread_pkg::preg_t secondary_rs2,
    output logic               primary_ready,
    output logic               read_en,
    output regread_pkg::preg_t read_rs1,
    output regread_pkg::preg_t read_rs2
);

    // The secondary unit always wins the port, so the ALU has to hold its request
    assign primary_ready = ~secondary_en;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            read_en <= 1'b0;
        end else begin
            read_en <= primary_en | secondary_en;
        end
    end

    always_ff @(posedge clk) begin
        if (secondary_en) begin
            read_rs1 <= secondary_rs1;
            read_rs2 <= secondary_rs2;
        end else begin
            read_rs1 <= primary_rs1;
            read_rs2 <= primary_rs2;
        end
    end

    read_en_known: assert property (
        @(posedge clk) disable iff (!rst_n)
        !$isunknown(read_en)
    ) else $error("read_port_share: read_en is unknown");

endmodule

`default_nettype wire

// File: hdl/regfile_wrapper.sv
`timescale 1ns/1ns
`default_nettype none

module regfile_wrapper (
    input  logic                                   clk,
    input  logic                                   rst_n,
    input  logic [regread_pkg::alu_size-1:0]       int_en,
    input  regread_pkg::preg_t                     int_preg   [2*regread_pkg::alu_size],
    output logic [regread_pkg::alu_size-1:0]       int_ready,
    output regread_pkg::word_t                     int_data   [2*regread_pkg::alu_size],
    input  logic                                   csr_en,
    input  regread_pkg::preg_t                     csr_preg   [2],
    output regread_pkg::word_t                     csr_data   [2],
    input  logic                                   mult_en,
    input  regread_pkg::preg_t                     mult_preg  [2],
    output regread_pkg::word_t                     mult_data  [2],
    input  logic [regread_pkg::load_pipeline-1:0]  load_en,
    input  regread_pkg::preg_t                     load_preg  [regread_pkg::load_pipeline],
    output regread_pkg::word_t                     load_data  [regread_pkg::load_pipeline],
    input  logic [2*regread_pkg::store_pipeline-1:0] store_en,
    input  regread_pkg::preg_t                     store_preg [2*regread_pkg::store_pipeline],
    output regread_pkg::word_t                     store_data [2*regread_pkg::store_pipeline],
    input  logic [regread_pkg::wb_size-1:0]        wb_en,
    input  logic [regread_pkg::wb_size-1:0]        wb_we,
    input  regread_pkg::preg_t                     wb_rd      [regread_pkg::wb_size],
    input  regread_pkg::word_t                     wb_res     [regread_pkg::wb_size]
);
    import regread_pkg::*;

    logic [alu_size-1:0]         sec_en;
    preg_t                       sec_rs1 [alu_size];
    preg_t                       sec_rs2 [alu_size];
    logic [alu_size-1:0]         alu_rd_en;
    preg_t                       alu_rs1 [alu_size];
    preg_t                       alu_rs2 [alu_size];
    logic [load_pipeline-1:0]    load_en_q;
    preg_t                       load_preg_q [load_pipeline];
    logic [2*store_pipeline-1:0] store_en_q;
    preg_t                       store_preg_q [2*store_pipeline];
    logic [wb_size-1:0]          we;
    preg_t                       raddr [int_read_ports];
    word_t                       rf_rdata [int_read_ports];
    word_t                       rdata [int_read_ports];

    // CSR borrows ALU pipe 0 and the multiplier borrows ALU pipe 1
    for (genvar i = 0; i < alu_size; i++) begin : g_alu
        if (i == 0) begin : g_csr
            assign sec_en[i]  = csr_en;
            assign sec_rs1[i] = csr_preg[0];
            assign sec_rs2[i] = csr_preg[1];
        end else if (i == 1) begin : g_mult
            assign sec_en[i]  = mult_en;
            assign sec_rs1[i] = mult_preg[0];
            assign sec_rs2[i] = mult_preg[1];
        end else begin : g_plain
            assign sec_en[i]  = 1'b0;
            assign sec_rs1[i] = '0;
            assign sec_rs2[i] = '0;
        end

        read_port_share u_share (
            .clk           (clk),
            .rst_n         (rst_n),
            .primary_en    (int_en[i]),
            .primary_rs1   (int_preg[i]),
            .primary_rs2   (int_preg[alu_size+i]),
            .secondary_en  (sec_en[i]),
            .secondary_rs1 (sec_rs1[i]),
            .secondary_rs2 (sec_rs2[i]),
            .primary_ready (int_ready[i]),
            .read_en       (alu_rd_en[i]),
            .read_rs1      (alu_rs1[i]),
            .read_rs2      (alu_rs2[i])
        );

        // An idle port reads register 0 so its address lines stay quiet
        assign raddr[i]          = alu_rd_en[i] ? alu_rs1[i] : '0;
        assign raddr[alu_size+i] = alu_rd_en[i] ? alu_rs2[i] : '0;
    end

    // Loads and stores own their ports outright and are never refused
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            load_en_q  <= '0;
            store_en_q <= '0;
        end else begin
            load_en_q  <= load_en;
            store_en_q <= store_en;
        end
    end

    always_ff @(posedge clk) begin
        load_preg_q  <= load_preg;
        store_preg_q <= store_preg;
    end

    for (genvar i = 0; i < load_pipeline; i++) begin : g_load
        assign raddr[load_base+i] = load_en_q[i] ? load_preg_q[i] : '0;
        assign load_data[i]       = rdata[load_base+i];
    end

    for (genvar i = 0; i < 2 * store_pipeline; i++) begin : g_store
        assign raddr[store_base+i] = store_en_q[i] ? store_preg_q[i] : '0;
        assign store_data[i]       = rdata[store_base+i];
    end

    assign we = wb_en & wb_we;

    phys_regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .raddr (raddr),
        .we    (we),
        .waddr (wb_rd),
        .wdata (wb_res),
        .rdata (rf_rdata)
    );

    wb_bypass u_bypass (
        .raddr    (raddr),
        .rf_rdata (rf_rdata),
        .we       (we),
        .waddr    (wb_rd),
        .wdata    (wb_res),
        .rdata    (rdata)
    );

    for (genvar i = 0; i < alu_size; i++) begin : g_alu_data
        assign int_data[i]          = rdata[i];
        assign int_data[alu_size+i] = rdata[alu_size+i];
    end

    // The borrowing units see the data of the ALU port pair they displaced
    assign csr_data[0]  = rdata[0];
    assign csr_data[1]  = rdata[alu_size];
    assign mult_data[0] = rdata[1];
    assign mult_data[1] = rdata[alu_size+1];

endmodule

`default_nettype wire

// File: hdl/regread_pkg.sv
`default_nettype none

package regread_pkg;

    // Datapath width and size of the integer physical register file
    localparam int xlen = 32;
    localparam int preg_size = 64;
    localparam int preg_width = $clog2(preg_size);

    // Issue pipes that read the integer file
    localparam int alu_size = 2;
    localparam int load_pipeline = 2;

    // Each store pipe reads an address operand and a data operand
    localparam int store_pipeline = 1;

    // Writeback ports into the register file
    localparam int wb_size = 4;

    // Read port layout, low index first:
    //   rs1 of each ALU pipe, rs2 of each ALU pipe, loads, then store operands
    localparam int int_read_ports = alu_size * 2 + load_pipeline + store_pipeline * 2;

    // First read port of the load group and of the store group
    localparam int load_base = alu_size * 2;
    localparam int store_base = load_base + load_pipeline;

    // Physical register number
    typedef logic [preg_width-1:0] preg_t;

    // Register value
    typedef logic [xlen-1:0] word_t;

endpackage

`default_nettype wire

// File: hdl/wb_bypass.sv
`timescale 1ns/1ns
`default_nettype none

module wb_bypass (
    input  regread_pkg::preg_t              raddr    [regread_pkg::int_read_ports],
    input  regread_pkg::word_t              rf_rdata [regread_pkg::int_read_ports],
    input  logic [regread_pkg::wb_size-1:0] we,
    input  regread_pkg::preg_t              waddr    [regread_pkg::wb_size],
    input  regread_pkg::word_t              wdata    [regread_pkg::wb_size],
    output regread_pkg::word_t              rdata    [regread_pkg::int_read_ports]
);
    import regread_pkg::*;

    // A result written back in the read cycle is not in the array until the edge,
    // so it is taken straight from the writeback bus
    always_comb begin
        for (int p = 0; p < int_read_ports; p++) begin
            rdata[p] = rf_rdata[p];
            for (int w = 0; w < wb_size; w++) begin
                // Register 0 never forwards, it must stay zero
                if (we[w] && waddr[w] != '0 && waddr[w] == raddr[p]) begin
                    rdata[p] = wdata[w];
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: run_sim.sh
#!/bin/sh
# Builds the register-read testbench with Verilator and runs it.
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    --top-module regread_tb \
    -f verilog.f \
    -o Vregread_tb

# The log decides the outcome, so the simulator's own exit status is not used here
./obj_dir/Vregread_tb | tee sim.log

if grep -qx "RESULT: PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// File: verif/regread_tb.sv
`timescale 1ns/1ns
`default_nettype none

module regread_tb;
    import regread_pkg::*;

    localparam int reset_cycles = 8;
    localparam int quiet_cycles = 16;
    localparam int num_cycles = 2000;
    // 8 reset cycles and 2000 random cycles, with room to spare
    localparam int timeout_cycles = 2500;

    logic                        clk;
    logic                        rst_n;
    logic [alu_size-1:0]         int_en;
    preg_t                       int_preg [2*alu_size];
    logic [alu_size-1:0]         int_ready;
    word_t                       int_data [2*alu_size];
    logic                        csr_en;
    preg_t                       csr_preg [2];
    word_t                       csr_data [2];
    logic                        mult_en;
    preg_t                       mult_preg [2];
    word_t                       mult_data [2];
    logic [load_pipeline-1:0]    load_en;
    preg_t                       load_preg [load_pipeline];
    word_t                       load_data [load_pipeline];
    logic [2*store_pipeline-1:0] store_en;
    preg_t                       store_preg [2*store_pipeline];
    word_t                       store_data [2*store_pipeline];
    logic [wb_size-1:0]          wb_en;
    logic [wb_size-1:0]          wb_we;
    preg_t                       wb_rd [wb_size];
    word_t                       wb_res [wb_size];

    // Requests as they were sampled at the last rising edge
    logic [alu_size-1:0]         prev_int_en;
    preg_t                       prev_int_preg [2*alu_size];
    logic                        prev_csr_en;
    preg_t                       prev_csr_preg [2];
    logic                        prev_mult_en;
    preg_t                       prev_mult_preg [2];
    logic [load_pipeline-1:0]    prev_load_en;
    preg_t                       prev_load_preg [load_pipeline];
    logic [2*store_pipeline-1:0] prev_store_en;
    preg_t                       prev_store_preg [2*store_pipeline];

    word_t       model [preg_size];
    logic [31:0] rng_state = 32'h6352_a4cd;
    int          error_count = 0;
    int          cycle_count = 0;
    string       phase = "reset_zero";

    regfile_wrapper dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .int_en     (int_en),
        .int_preg   (int_preg),
        .int_ready  (int_ready),
        .int_data   (int_data),
        .csr_en     (csr_en),
        .csr_preg   (csr_preg),
        .csr_data   (csr_data),
        .mult_en    (mult_en),
        .mult_preg  (mult_preg),
        .mult_data  (mult_data),
        .load_en    (load_en),
        .load_preg  (load_preg),
        .load_data  (load_data),
        .store_en   (store_en),
        .store_preg (store_preg),
        .store_data (store_data),
        .wb_en      (wb_en),
        .wb_we      (wb_we),
        .wb_rd      (wb_rd),
        .wb_res     (wb_res)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_cycles) begin
            $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
            $display("RESULT: FAIL");
            $fatal(1, "timeout");
        end
    end

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Three draws in four land on p0..p15 so reads and writes collide often
    function automatic preg_t rand_preg();
        logic [31:0] r;
        r = next_rand();
        if (r[1:0] != 2'b00) begin
            return {2'b00, r[5:2]};
        end
        return r[13:8];
    endfunction

    // Bypass first, then the array state after the last edge; p0 is always zero
    function automatic word_t expected_value(input preg_t r);
        word_t v;
        v = model[r];
        for (int w = 0; w < wb_size; w++) begin
            if (wb_en[w] && wb_we[w] && wb_rd[w] == r) begin
                v = wb_res[w];
            end
        end
        if (r == '0) begin
            v = '0;
        end
        return v;
    endfunction

    task automatic check_data(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected %h actual %h", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "data mismatch");
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            error_count++;
            $display("** Error: %s expected %b actual %b", name, expected, actual);
            $display("RESULT: FAIL");
            $fatal(1, "ready mismatch");
        end
    endtask

    task automatic commit_writebacks();
        for (int w = 0; w < wb_size; w++) begin
            if (wb_en[w] && wb_we[w] && wb_rd[w] != '0) begin
                model[wb_rd[w]] = wb_res[w];
            end
        end
    endtask

    task automatic save_requests();
        prev_int_en = int_en;
        prev_int_preg = int_preg;
        prev_csr_en = csr_en;
        prev_csr_preg = csr_preg;
        prev_mult_en = mult_en;
        prev_mult_preg = mult_preg;
        prev_load_en = load_en;
        prev_load_preg = load_preg;
        prev_store_en = store_en;
        prev_store_preg = store_preg;
    endtask

    task automatic drive_random(input bit allow_writes);
        logic [alu_size-1:0] hold;
        preg_t               hot [8];
        logic [31:0]         r;
        hold[0] = int_en[0] && csr_en;
        hold[1] = int_en[1] && mult_en;
        r = next_rand();
        csr_en = r[1:0] == 2'b00;
        mult_en = r[3:2] == 2'b00;
        csr_preg[0] = rand_preg();
        csr_preg[1] = rand_preg();
        mult_preg[0] = rand_preg();
        mult_preg[1] = rand_preg();
        // A refused ALU request stays on the bus until it is taken
        for (int i = 0; i < alu_size; i++) begin
            if (!hold[i]) begin
                int_en[i] = r[4+i];
                int_preg[i] = rand_preg();
                int_preg[alu_size+i] = rand_preg();
            end
        end
        for (int i = 0; i < load_pipeline; i++) begin
            load_en[i] = r[8+i];
            load_preg[i] = rand_preg();
        end
        for (int i = 0; i < 2 * store_pipeline; i++) begin
            store_en[i] = r[12+i];
            store_preg[i] = rand_preg();
        end
        // Registers whose data is due this cycle make good bypass targets
        for (int i = 0; i < 2 * alu_size; i++) begin
            hot[i] = prev_int_preg[i];
        end
        hot[4] = prev_load_preg[0];
        hot[5] = prev_load_preg[1];
        hot[6] = prev_store_preg[0];
        hot[7] = prev_store_preg[1];
        for (int w = 0; w < wb_size; w++) begin
            r = next_rand();
            wb_en[w] = allow_writes && (r[0] || r[1]);
            wb_we[w] = r[2] || r[3];
            wb_rd[w] = (r[5:4] != 2'b00) ? hot[r[8:6]] : rand_preg();
            wb_res[w] = next_rand();
            for (int v = 0; v < w; v++) begin
                if (wb_en[v] && wb_we[v] && wb_rd[v] == wb_rd[w] && wb_rd[w] != '0) begin
                    wb_we[w] = 1'b0;
                end
            end
        end
    endtask

    task automatic check_outputs(input int cyc);
        string tag;
        tag = $sformatf("%s cycle %0d", phase, cyc);
        check_ready({tag, " int_ready0"}, ~csr_en, int_ready[0]);
        check_ready({tag, " int_ready1"}, ~mult_en, int_ready[1]);
        if (prev_csr_en) begin
            check_data({tag, " csr rs1"}, expected_value(prev_csr_preg[0]), csr_data[0]);
            check_data({tag, " csr rs2"}, expected_value(prev_csr_preg[1]), csr_data[1]);
        end else if (prev_int_en[0]) begin
            check_data({tag, " alu0 rs1"}, expected_value(prev_int_preg[0]), int_data[0]);
            check_data({tag, " alu0 rs2"}, expected_value(prev_int_preg[2]), int_data[2]);
        end
        if (prev_mult_en) begin
            check_data({tag, " mult rs1"}, expected_value(prev_mult_preg[0]), mult_data[0]);
            check_data({tag, " mult rs2"}, expected_value(prev_mult_preg[1]), mult_data[1]);
        end else if (prev_int_en[1]) begin
            check_data({tag, " alu1 rs1"}, expected_value(prev_int_preg[1]), int_data[1]);
            check_data({tag, " alu1 rs2"}, expected_value(prev_int_preg[3]), int_data[3]);
        end
        for (int i = 0; i < load_pipeline; i++) begin
            if (prev_load_en[i]) begin
                check_data($sformatf("%s load%0d", tag, i),
                           expected_value(prev_load_preg[i]), load_data[i]);
            end
        end
        for (int i = 0; i < 2 * store_pipeline; i++) begin
            if (prev_store_en[i]) begin
                check_data($sformatf("%s store op%0d", tag, i),
                           expected_value(prev_store_preg[i]), store_data[i]);
            end
        end
    endtask

    initial begin
        rst_n = 1'b0;
        int_en = '0;
        csr_en = 1'b0;
        mult_en = 1'b0;
        load_en = '0;
        store_en = '0;
        wb_en = '0;
        wb_we = '0;
        for (int i = 0; i < 2; i++) begin
            int_preg[i] = '0;
            int_preg[alu_size+i] = '0;
            csr_preg[i] = '0;
            mult_preg[i] = '0;
            load_preg[i] = '0;
            store_preg[i] = '0;
        end
        for (int w = 0; w < wb_size; w++) begin
            wb_rd[w] = '0;
            wb_res[w] = '0;
        end
        for (int r = 0; r < preg_size; r++) begin
            model[r] = '0;
        end
        save_requests();
        repeat (reset_cycles) @(posedge clk);
        #1 rst_n = 1'b1;

        // The first cycles read without any writeback, so everything must be zero
        for (int cyc = 0; cyc < num_cycles; cyc++) begin
            @(posedge clk);
            commit_writebacks();
            save_requests();
            if (cyc == quiet_cycles) begin
                phase = "random";
            end
            #1;
            drive_random(cyc >= quiet_cycles);
            #3;
            check_outputs(cyc);
        end

        if (error_count == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("RESULT: FAIL");
            $fatal(1, "%0d checks failed", error_count);
        end
    end

endmodule

`default_nettype wire

// File: verilog.f
hdl/regread_pkg.sv
hdl/read_port_share.sv
hdl/phys_regfile.sv
hdl/wb_bypass.sv
hdl/regfile_wrapper.sv
verif/regread_tb.sv
